// ==== logic/rf_pipe_pkg.sv ====
`default_nettype none

package rf_pipe_pkg;

  // Register file geometry
  localparam int rf_depth = 16;
  localparam int rf_width = 32;
  // Address width follows the depth
  localparam int rf_addr_w = $clog2(rf_depth);

  typedef logic [rf_addr_w-1:0] rf_addr_t;
  typedef logic [rf_width-1:0]  rf_data_t;

  // Command opcode
  // A no-op walks the pipe without touching the RAM
  typedef enum logic {
    op_nop  = 1'b0,
    op_read = 1'b1
  } rf_op_e;

  // Read command carried through p0, p1 and p2
  typedef struct packed {
    rf_op_e   op;
    rf_addr_t addr;
  } rd_cmd_t;

  // Result presented by p2
  typedef struct packed {
    rf_op_e   op;
    rf_addr_t addr;
    rf_data_t data;
  } rd_rsp_t;

  // Write request from outside
  typedef struct packed {
    rf_addr_t addr;
    rf_data_t data;
  } wr_cmd_t;

  // RAM read request from the issue stage
  typedef struct packed {
    logic     en;
    rf_addr_t addr;
  } ram_rd_t;

endpackage

`default_nettype wire

// ==== logic/rf_storage.sv ====
`default_nettype none

module rf_storage
  import rf_pipe_pkg::*;
(
    input  logic     clk
  , input  logic     rst_n
  , input  logic     wr_v
  , input  wr_cmd_t  wr_cmd
  , input  ram_rd_t  ram_rd
  , output rf_data_t ram_data
);

  // Storage words
  rf_data_t mem [0:rf_depth-1];

  // Write staging, one entry deep
  logic    wr_stage_v;
  wr_cmd_t wr_stage;

  // Registered read data
  rf_data_t rd_data_q;

  // Staging valid follows the write port by one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_stage_v <= 1'b0;
    end else begin
      // Every write is taken, no back-pressure
      wr_stage_v <= wr_v;
    end
  end

  // Address and data of the staged write
  always_ff @(posedge clk) begin
    if (wr_v) begin
      wr_stage <= wr_cmd;
    end
  end

  // Array update one edge after the write was accepted
  always_ff @(posedge clk) begin
    if (wr_stage_v) begin
      mem[wr_stage.addr] <= wr_stage.data;
    end
  end

  // Read port
  // Word appears one cycle after the enabled read and holds otherwise
  always_ff @(posedge clk) begin
    if (ram_rd.en) begin
      rd_data_q <= mem[ram_rd.addr];
    end
  end

  assign ram_data = rd_data_q;

endmodule

`default_nettype wire

// ==== logic/rf_read_issue.sv ====
`default_nettype none

module rf_read_issue
  import rf_pipe_pkg::*;
(
    input  logic    clk
  , input  logic    rst_n
  , input  logic    in_v
  , input  rd_cmd_t in_cmd
  , input  logic    p0_hold
  , input  logic    p1_stall
  , output logic    in_stall
  , output logic    p0_v
  , output rd_cmd_t p0_cmd
  , output ram_rd_t ram_rd
  , output logic    rd_live
);

  logic    p0_v_q;
  rd_cmd_t p0_cmd_q;
  logic    rd_live_q;

  // Effective p0 hold
  logic    p0_stall;
  // New command taken into p0 this cycle
  logic    p0_load;
  logic    p0_is_read;

  // p0 holds on its own request or when p1 cannot take the command
  assign p0_stall = p0_v_q & (p0_hold | p1_stall);
  assign p0_load  = in_v & ~p0_stall;

  // Source must keep the command steady while this is high
  assign in_stall = in_v & p0_stall;

  assign p0_is_read = p0_v_q & (p0_cmd_q.op == op_read);

  // RAM read goes out every cycle a read sits in p0
  // A held read simply repeats, which keeps the port free of input paths
  always_comb begin
    ram_rd.en   = p0_is_read;
    ram_rd.addr = p0_cmd_q.addr;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      p0_v_q    <= 1'b0;
      rd_live_q <= 1'b0;
    end else begin
      // Stay valid while holding, refill on an accepted command
      p0_v_q    <= p0_load | p0_stall;
      // Read data counts only when p1 was free to move on
      // A repeat under a p1 stall is marked stale
      rd_live_q <= p0_is_read & ~p1_stall;
    end
  end

  // Command payload
  always_ff @(posedge clk) begin
    if (p0_load) begin
      p0_cmd_q <= in_cmd;
    end
  end

  assign p0_v    = p0_v_q;
  assign p0_cmd  = p0_cmd_q;
  assign rd_live = rd_live_q;

endmodule

`default_nettype wire

// ==== logic/rf_read_align.sv ====
`default_nettype none

module rf_read_align
  import rf_pipe_pkg::*;
(
    input  logic     clk
  , input  logic     rst_n
  , input  logic     p0_v
  , input  rd_cmd_t  p0_cmd
  , input  logic     p0_hold
  , input  logic     p1_hold
  , input  logic     p2_stall
  , input  rf_data_t ram_data
  , input  logic     rd_live
  , output logic     p1_v
  , output rd_cmd_t  p1_cmd
  , output rf_data_t p1_data
  , output logic     p1_stall
);

  logic     p1_v_q;
  rd_cmd_t  p1_cmd_q;
  rf_data_t p1_data_q;

  // Handover from p0
  logic p1_load;
  // Live RAM word must be parked here
  logic p1_catch;

  // Effective p1 hold, own request or p2 full
  assign p1_stall = p1_v_q & (p1_hold | p2_stall);

  // p0 hands over unless it holds itself or p1 is stuck
  assign p1_load = p0_v & ~p0_hold & ~p1_stall;

  // RAM word belongs to the command in p1
  // If p1 cannot move this cycle the word would be gone next cycle
  assign p1_catch = p1_stall & rd_live;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      p1_v_q <= 1'b0;
    end else begin
      p1_v_q <= p1_load | p1_stall;
    end
  end

  // Command follows p0
  always_ff @(posedge clk) begin
    if (p1_load) begin
      p1_cmd_q <= p0_cmd;
    end
  end

  // Parked read data, capture picks it up when the RAM word is stale
  always_ff @(posedge clk) begin
    if (p1_catch) begin
      p1_data_q <= ram_data;
    end
  end

  assign p1_v    = p1_v_q;
  assign p1_cmd  = p1_cmd_q;
  assign p1_data = p1_data_q;

endmodule

`default_nettype wire

// ==== logic/rf_read_capture.sv ====
`default_nettype none

module rf_read_capture
  import rf_pipe_pkg::*;
(
    input  logic     clk
  , input  logic     rst_n
  , input  logic     p1_v
  , input  rd_cmd_t  p1_cmd
  , input  rf_data_t p1_data
  , input  logic     p1_hold
  , input  logic     p2_hold
  , input  rf_data_t ram_data
  , input  logic     rd_live
  , output logic     p2_v
  , output rd_rsp_t  p2_rsp
  , output logic     p2_stall
);

  logic    p2_v_q;
  rd_rsp_t p2_rsp_q;

  // Handover from p1
  logic     p2_load;
  // Data chosen for the incoming command
  rf_data_t p2_data_sel;

  // Last stage, only its own hold counts
  assign p2_stall = p2_v_q & p2_hold;

  assign p2_load = p1_v & ~p1_hold & ~p2_stall;

  // Live word comes straight from the RAM port
  // Otherwise the word parked in p1 is used
  // For a no-op neither is meaningful and the field is don't-care
  assign p2_data_sel = rd_live ? ram_data : p1_data;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      p2_v_q <= 1'b0;
    end else begin
      // Retires on a cycle with p2_v high and p2_hold low
      p2_v_q <= p2_load | p2_stall;
    end
  end

  // Result payload
  always_ff @(posedge clk) begin
    if (p2_load) begin
      p2_rsp_q.op   <= p1_cmd.op;
      p2_rsp_q.addr <= p1_cmd.addr;
      p2_rsp_q.data <= p2_data_sel;
    end
  end

  assign p2_v   = p2_v_q;
  assign p2_rsp = p2_rsp_q;

endmodule

`default_nettype wire

// ==== logic/rf_mem_pipe.sv ====
`default_nettype none

module rf_mem_pipe
  import rf_pipe_pkg::*;
(
    input  logic    clk
  , input  logic    rst_n
  // Command port
  , input  logic    in_v
  , input  rd_cmd_t in_cmd
  , output logic    in_stall
  // Per-stage holds, only while that stage is valid
  , input  logic    p0_hold
  , input  logic    p1_hold
  , input  logic    p2_hold
  // Write port, always accepted
  , input  logic    wr_v
  , input  wr_cmd_t wr_cmd
  // Stage status and result
  , output logic    p0_v
  , output logic    p1_v
  , output logic    p2_v
  , output rd_rsp_t p2_rsp
);

  // p0 to p1
  rd_cmd_t  p0_cmd;
  // p1 to p2
  rd_cmd_t  p1_cmd;
  rf_data_t p1_data;

  // Back-pressure chain p2 to p1 to p0
  logic     p1_stall;
  logic     p2_stall;

  // RAM read path
  ram_rd_t  ram_rd;
  rf_data_t ram_data;
  logic     rd_live;

  // p0, takes commands and drives the RAM read
  rf_read_issue i_issue (
      .clk      (clk)
    , .rst_n    (rst_n)
    , .in_v     (in_v)
    , .in_cmd   (in_cmd)
    , .p0_hold  (p0_hold)
    , .p1_stall (p1_stall)
    , .in_stall (in_stall)
    , .p0_v     (p0_v)
    , .p0_cmd   (p0_cmd)
    , .ram_rd   (ram_rd)
    , .rd_live  (rd_live)
  );

  // p1, lines up with the RAM word
  rf_read_align i_align (
      .clk      (clk)
    , .rst_n    (rst_n)
    , .p0_v     (p0_v)
    , .p0_cmd   (p0_cmd)
    , .p0_hold  (p0_hold)
    , .p1_hold  (p1_hold)
    , .p2_stall (p2_stall)
    , .ram_data (ram_data)
    , .rd_live  (rd_live)
    , .p1_v     (p1_v)
    , .p1_cmd   (p1_cmd)
    , .p1_data  (p1_data)
    , .p1_stall (p1_stall)
  );

  // p2, result register
  rf_read_capture i_capture (
      .clk      (clk)
    , .rst_n    (rst_n)
    , .p1_v     (p1_v)
    , .p1_cmd   (p1_cmd)
    , .p1_data  (p1_data)
    , .p1_hold  (p1_hold)
    , .p2_hold  (p2_hold)
    , .ram_data (ram_data)
    , .rd_live  (rd_live)
    , .p2_v     (p2_v)
    , .p2_rsp   (p2_rsp)
    , .p2_stall (p2_stall)
  );

  // Array with staged write and registered read
  rf_storage i_storage (
      .clk      (clk)
    , .rst_n    (rst_n)
    , .wr_v     (wr_v)
    , .wr_cmd   (wr_cmd)
    , .ram_rd   (ram_rd)
    , .ram_data (ram_data)
  );

endmodule

`default_nettype wire

// ==== tb/rf_pipe_checker.sv ====
`default_nettype none

module rf_pipe_checker
  import rf_pipe_pkg::*;
(
    input  logic                clk
  , input  logic                rst_n
  , input  logic                in_v
  , input  rd_cmd_t             in_cmd
  , input  logic                in_stall
  , input  rf_data_t            exp_data
  , input  logic                p0_v
  , input  logic                p0_hold
  , input  logic                p1_v
  , input  logic                p1_hold
  , input  logic                p2_v
  , input  logic                p2_hold
  , input  rd_rsp_t             p2_rsp
  , output logic [rf_depth-1:0] busy_mask
  , output int                  err_cnt
  , output int                  acc_cnt
  , output int                  ret_cnt
);

  // Outstanding results, oldest first
  rd_rsp_t exp_q[$];

  initial begin
    err_cnt   = 0;
    acc_cnt   = 0;
    ret_cnt   = 0;
    busy_mask = '0;
  end

  // Sampled mid-cycle, so the values are the ones seen at the coming edge
  always @(negedge clk) begin : check_edge
    rd_rsp_t exp;
    logic    p2_eff;
    logic    p1_eff;
    logic    exp_stall;
    int      occ;
    if (!rst_n) begin
      // Reset clears every stage and the input stall
      if (p0_v !== 1'b0 || p1_v !== 1'b0 || p2_v !== 1'b0 || in_stall !== 1'b0) begin
        err_cnt++;
        $display("A stage valid or the input stall is set during reset");
      end
    end else begin
      // Hold chain from p2 back to the input
      p2_eff    = p2_v & p2_hold;
      p1_eff    = p1_v & (p1_hold | p2_eff);
      exp_stall = in_v & p0_v & (p0_hold | p1_eff);
      if (in_stall !== exp_stall) begin
        err_cnt++;
        $display("Error in_stall: expected %b, actual %b", exp_stall, in_stall);
      end
      // Each command in flight sits in exactly one valid stage
      occ = p0_v + p1_v + p2_v;
      if (occ != exp_q.size()) begin
        err_cnt++;
        $display("Error occupancy: expected %0d, actual %0d", exp_q.size(), occ);
      end
      // Result leaves p2 at the coming edge
      if (p2_v && !p2_hold) begin
        if (exp_q.size() == 0) begin
          err_cnt++;
          $display("A result retired while no command was outstanding");
        end else begin
          exp = exp_q.pop_front();
          ret_cnt++;
          if (p2_rsp.op !== exp.op) begin
            err_cnt++;
            $display("Error result_op: expected %0d, actual %0d", exp.op, p2_rsp.op);
          end
          if (p2_rsp.addr !== exp.addr) begin
            err_cnt++;
            $display("Error result_addr: expected %h, actual %h", exp.addr, p2_rsp.addr);
          end
          // No-op data is undefined
          if (exp.op == op_read && p2_rsp.data !== exp.data) begin
            err_cnt++;
            $display("Error read_data at %h: expected %h, actual %h",
                     exp.addr, exp.data, p2_rsp.data);
          end
        end
      end
      // Command taken at the coming edge
      if (in_v && in_stall === 1'b0) begin
        exp_q.push_back({in_cmd, exp_data});
        acc_cnt++;
      end
      // Addresses with a read still in flight
      busy_mask = '0;
      foreach (exp_q[i]) begin
        if (exp_q[i].op == op_read) begin
          busy_mask[exp_q[i].addr] = 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_rf_mem_pipe.sv ====
`default_nettype none

module tb_rf_mem_pipe
  import rf_pipe_pkg::*;
();

  logic                clk;
  logic                rst_n;
  logic                in_v;
  rd_cmd_t             in_cmd;
  logic                in_stall;
  rf_data_t            exp_data;
  logic                p0_hold;
  logic                p1_hold;
  logic                p2_hold;
  logic                wr_v;
  wr_cmd_t             wr_cmd;
  logic                p0_v;
  logic                p1_v;
  logic                p2_v;
  rd_rsp_t             p2_rsp;
  logic [rf_depth-1:0] busy_mask;
  int                  err_cnt;
  int                  acc_cnt;
  int                  ret_cnt;

  // Stimulus table, one entry per file line
  logic [7:0] kind_a [0:63];
  rf_addr_t   addr_a [0:63];
  rf_data_t   data_a [0:63];
  int         n_lines;
  int         n_cmds;
  int         tb_err;
  bit         aborted;
  integer     seed;

  rf_mem_pipe i_dut (
      .clk(clk), .rst_n(rst_n), .in_v(in_v), .in_cmd(in_cmd), .in_stall(in_stall)
    , .p0_hold(p0_hold), .p1_hold(p1_hold), .p2_hold(p2_hold)
    , .wr_v(wr_v), .wr_cmd(wr_cmd)
    , .p0_v(p0_v), .p1_v(p1_v), .p2_v(p2_v), .p2_rsp(p2_rsp)
  );

  rf_pipe_checker i_checker (
      .clk(clk), .rst_n(rst_n), .in_v(in_v), .in_cmd(in_cmd), .in_stall(in_stall)
    , .exp_data(exp_data), .p0_v(p0_v), .p0_hold(p0_hold), .p1_v(p1_v), .p1_hold(p1_hold)
    , .p2_v(p2_v), .p2_hold(p2_hold), .p2_rsp(p2_rsp)
    , .busy_mask(busy_mask), .err_cnt(err_cnt), .acc_cnt(acc_cnt), .ret_cnt(ret_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Random holds, each only while its stage is valid
  initial begin
    seed    = 83;
    p0_hold = 1'b0;
    p1_hold = 1'b0;
    p2_hold = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      p0_hold = rst_n & p0_v & (($random(seed) & 3) == 0);
      p1_hold = rst_n & p1_v & (($random(seed) & 3) == 0);
      p2_hold = rst_n & p2_v & (($random(seed) & 3) == 0);
    end
  end

  // Kind letter, hex address, hex data; lines starting with # are skipped
  task automatic load_stimulus();
    int         fd;
    int         code;
    int         ch;
    logic [7:0] c;
    rf_addr_t   a;
    rf_data_t   d;
    n_lines = 0;
    fd = $fopen("tb/rf_pipe_stimulus.txt", "r");
    if (fd == 0) begin
      tb_err++;
      aborted = 1'b1;
      $display("Cannot open the stimulus file tb/rf_pipe_stimulus.txt");
    end else begin
      code = $fscanf(fd, " %c", c);
      while (code == 1) begin
        if (c == "#") begin
          ch = $fgetc(fd);
          while (ch != 'h0a && ch != -1) begin
            ch = $fgetc(fd);
          end
        end else begin
          code = $fscanf(fd, "%h %h", a, d);
          kind_a[n_lines] = c;
          addr_a[n_lines] = a;
          data_a[n_lines] = d;
          n_lines++;
        end
        code = $fscanf(fd, " %c", c);
      end
      $fclose(fd);
    end
  endtask

  task automatic send_cmd(input int idx);
    int wait_cnt;
    bit taken;
    wait_cnt    = 0;
    taken       = 1'b0;
    in_v        = 1'b1;
    in_cmd.op   = (kind_a[idx] == "R") ? op_read : op_nop;
    in_cmd.addr = addr_a[idx];
    exp_data    = data_a[idx];
    while (!taken && !aborted) begin
      @(negedge clk);
      taken = !in_stall;
      @(posedge clk);
      #2;
      wait_cnt++;
      if (!taken && wait_cnt > 50) begin
        tb_err++;
        aborted = 1'b1;
        $display("Timeout: command of stimulus entry %0d was never accepted", idx);
      end
    end
    in_v = 1'b0;
  endtask

  task automatic send_write(input int idx);
    int wait_cnt;
    wait_cnt = 0;
    // Keep off an address that a read in flight still needs
    while (busy_mask[addr_a[idx]] && !aborted) begin
      @(posedge clk);
      #2;
      wait_cnt++;
      if (wait_cnt > 50) begin
        tb_err++;
        aborted = 1'b1;
        $display("Timeout: reads of address %h never left the pipe", addr_a[idx]);
      end
    end
    if (!aborted) begin
      wr_v        = 1'b1;
      wr_cmd.addr = addr_a[idx];
      wr_cmd.data = data_a[idx];
      @(posedge clk);
      #2;
      wr_v = 1'b0;
    end
  endtask

  task automatic wait_drain();
    int wait_cnt;
    wait_cnt = 0;
    while ((p0_v || p1_v || p2_v) && !aborted) begin
      @(posedge clk);
      #2;
      wait_cnt++;
      if (wait_cnt > 200) begin
        tb_err++;
        aborted = 1'b1;
        $display("Timeout: the pipe did not drain after the last command");
      end
    end
  endtask

  initial begin
    rst_n    = 1'b0;
    in_v     = 1'b0;
    in_cmd   = '0;
    exp_data = '0;
    wr_v     = 1'b0;
    wr_cmd   = '0;
    tb_err   = 0;
    n_cmds   = 0;
    aborted  = 1'b0;
    load_stimulus();
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    // Writes and commands in file order
    for (int i = 0; i < n_lines && !aborted; i++) begin
      if (kind_a[i] == "W") begin
        send_write(i);
      end else begin
        send_cmd(i);
        n_cmds++;
      end
    end
    wait_drain();
    if (!aborted && ret_cnt != acc_cnt) begin
      tb_err++;
      $display("Commands lost or duplicated: %0d sent, %0d accepted, %0d retired",
               n_cmds, acc_cnt, ret_cnt);
    end
    $display("Errors: %0d checker, %0d testbench; accepted %0d, retired %0d",
             err_cnt, tb_err, acc_cnt, ret_cnt);
    if (err_cnt + tb_err == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/rf_pipe_stimulus.txt ====
# kind (W write, R read, N no-op), address in hex, data in hex
# R data is the expected read value, N data is not compared
W 0 0000a0a0
W 1 1111b1b1
W 2 22c2c2c2
W 3 3d3d3d33
W 4 40e4e4e4
W 5 5f5f5f55
W 6 66000666
W 7 77717771
W 8 8a8a8a88
R 0 0000a0a0
R 1 1111b1b1
N 9 00000000
R 2 22c2c2c2
W 0 0badf00d
R 3 3d3d3d33
R 4 40e4e4e4
N c 00000000
R 5 5f5f5f55
R 6 66000666
R 7 77717771
R 8 8a8a8a88
N 3 00000000
R 0 0badf00d
R 2 22c2c2c2
R 1 1111b1b1
R 6 66000666

// ==== flist.f ====
logic/rf_pipe_pkg.sv
logic/rf_storage.sv
logic/rf_read_issue.sv
logic/rf_read_align.sv
logic/rf_read_capture.sv
logic/rf_mem_pipe.sv
tb/rf_pipe_checker.sv
tb/tb_rf_mem_pipe.sv
